// File: Makefile
# Verilator build and run of the cache testbench
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/line_array.sv
verilog/cache_ctrl.sv
verilog/line_update.sv
verilog/cache_top.sv
verification/tb_clock.sv
verification/cache_sva.sv
verification/cache_tb.sv

// File: verification/cache_stimulus.txt
// header: memory fill constant (xor with word address), operation count
// ops: kind (0 read, 1 write, 2 reset) addr wdata exp_rdata exp_fetch exp_wb exp_wb_line
C0DE0000
00000020
// cold read misses, then read hits
0 00000000 00000000 C0DE0000 1 0 00000000
0 00000005 00000000 C0DE0005 1 0 00000000
0 0000000E 00000000 C0DE000E 1 0 00000000
0 00000001 00000000 C0DE0001 0 0 00000000
0 00000003 00000000 C0DE0003 0 0 00000000
0 00000007 00000000 C0DE0007 0 0 00000000
// write hits
1 00000002 DEADBEEF 00000000 0 0 00000000
0 00000002 00000000 DEADBEEF 0 0 00000000
1 00000004 11112222 00000000 0 0 00000000
0 00000004 00000000 11112222 0 0 00000000
// dirty and clean evictions
0 00000020 00000000 C0DE0020 1 1 00000000
0 00000023 00000000 C0DE0023 0 0 00000000
0 0000002E 00000000 C0DE002E 1 0 00000000
0 0000000E 00000000 C0DE000E 1 0 00000000
0 00000000 00000000 C0DE0000 1 0 00000000
0 00000002 00000000 DEADBEEF 0 0 00000000
0 3FFFFFF8 00000000 FF21FFF8 1 0 00000000
1 3FFFFFF9 CAFEF00D 00000000 0 0 00000000
0 00000018 00000000 C0DE0018 1 1 0FFFFFFE
0 3FFFFFF9 00000000 CAFEF00D 1 0 00000000
// reset drops every line, dirty ones too
2 00000000 00000000 00000000 0 0 00000000
0 00000002 00000000 DEADBEEF 1 0 00000000
0 00000005 00000000 C0DE0005 1 0 00000000
0 00000004 00000000 C0DE0004 0 0 00000000
0 3FFFFFFB 00000000 FF21FFFB 1 0 00000000
0 3FFFFFF9 00000000 CAFEF00D 0 0 00000000
// write misses and ping-pong on index 7
1 0000001C 0BADC0DE 00000000 1 0 00000000
0 0000001C 00000000 0BADC0DE 0 0 00000000
1 0000003D 76543210 00000000 1 1 00000007
0 0000003D 00000000 76543210 0 0 00000000
0 0000001C 00000000 0BADC0DE 1 1 0000000F
0 0000003D 00000000 76543210 1 0 00000000

// File: verification/cache_sva.sv
// memory handshake assertions, bound into the cache controller
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_sva (
	input logic                   clk,
	input logic                   proc_reset,
	input logic                   proc_stall,
	input logic                   mem_read,
	input logic                   mem_write,
	input logic [`MEM_ADDR_W-1:0] mem_addr,
	input logic                   mem_ready
);

	// one request kind at a time
	property one_request;
		@(posedge clk) disable iff (proc_reset) !(mem_read && mem_write);
	endproperty

	// request and line address held until memory answers
	property read_held;
		@(posedge clk) disable iff (proc_reset)
			(mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr));
	endproperty

	property write_held;
		@(posedge clk) disable iff (proc_reset)
			(mem_write && !mem_ready) |=> (mem_write && $stable(mem_addr));
	endproperty

	property stall_on_request;
		@(posedge clk) disable iff (proc_reset) (mem_read || mem_write) |-> proc_stall;
	endproperty

	a_one_request: assert property (one_request)
		else $error("mem_read and mem_write high together");
	a_read_held: assert property (read_held)
		else $error("read request dropped or moved before mem_ready");
	a_write_held: assert property (write_held)
		else $error("write request dropped or moved before mem_ready");
	a_stall: assert property (stall_on_request)
		else $error("proc_stall low during a memory request");

endmodule

bind cache_ctrl cache_sva i_sva (
	.clk        (clk),
	.proc_reset (proc_reset),
	.proc_stall (proc_stall),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.mem_addr   (mem_addr),
	.mem_ready  (mem_ready)
);

// File: verification/cache_tb.sv
// testbench top, runs the stimulus file against the cache and a delayed line memory model
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb
	import cache_pkg::*;
();

	localparam int MAX_OPS    = 64;
	localparam int OP_WORDS   = 7;    // kind addr wdata rdata fetches wbs wb_line
	localparam int STIM_WORDS = 2 + MAX_OPS * OP_WORDS;

	logic clk;
	logic proc_reset;
	logic restart = 1'b0;

	logic                    proc_read  = 1'b0;
	logic                    proc_write = 1'b0;
	logic [`PROC_ADDR_W-1:0] proc_addr  = '0;
	word_t                   proc_wdata = '0;
	word_t                   proc_rdata;
	logic                    proc_stall;
	logic                    mem_read;
	logic                    mem_write;
	logic [`MEM_ADDR_W-1:0]  mem_addr;
	line_t                   mem_wdata;
	line_t                   mem_rdata = '0;
	logic                    mem_ready = 1'b0;

	logic [31:0] stim [STIM_WORDS];
	word_t       mem_xor;
	int          n_ops;
	int          checks;
	int          errors;
	int          watchdog_cycles;

	// memory model state
	line_t                  mem_store [logic [`MEM_ADDR_W-1:0]];
	logic                   mem_busy = 1'b0;
	logic [2:0]             wait_cnt = '0;
	logic [2:0]             delay;
	logic [7:0]             lfsr_state = 8'd75;
	int                     fetch_count = 0;
	int                     wb_count = 0;
	logic [`MEM_ADDR_W-1:0] last_wb_line = '0;

	tb_clock i_clock (.clk(clk), .proc_reset(proc_reset), .restart(restart));

	cache_top i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	// ----------------------------------------
	// memory model

	// galois form, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 8'hB8;
		end
		return s >> 1;
	endfunction

	// untouched words hold their word address xor the header constant
	function automatic line_t memory_line(input logic [`MEM_ADDR_W-1:0] line_addr);
		line_t l;
		if (mem_store.exists(line_addr)) begin
			return mem_store[line_addr];
		end
		for (int w = 0; w < (1 << `OFFSET_W); w++) begin
			l[w * `WORD_W +: `WORD_W] = 32'({line_addr, 2'(w)}) ^ mem_xor;
		end
		return l;
	endfunction

	always @(posedge clk) begin
		mem_ready <= 1'b0;
		if (proc_reset) begin
			mem_busy <= 1'b0;
		end else if (mem_busy) begin
			if (wait_cnt == 3'd0) begin
				mem_ready <= 1'b1;
				mem_busy  <= 1'b0;
				if (mem_write) begin
					mem_store[mem_addr] = mem_wdata;
					wb_count     <= wb_count + 1;
					last_wb_line <= mem_addr;
				end else begin
					mem_rdata   <= memory_line(mem_addr);
					fetch_count <= fetch_count + 1;
				end
			end else begin
				wait_cnt <= wait_cnt - 3'd1;
			end
		end else if ((mem_read || mem_write) && !mem_ready) begin
			for (int i = 0; i < 3; i++) begin
				delay[i]   = lfsr_state[0];    // one step per bit
				lfsr_state = lfsr_next(lfsr_state);
			end
			mem_busy <= 1'b1;
			wait_cnt <= delay;    // 1 to 8 cycles
		end
	end

	// ----------------------------------------
	// checks and operations

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error: %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// bus must stay idle for as long as reset is held
	task automatic watch_reset_bus();
		@(negedge clk);
		while (proc_reset) begin
			check_value("mem_read", 32'(mem_read), 32'd0);
			check_value("mem_write", 32'(mem_write), 32'd0);
			@(negedge clk);
		end
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		watch_reset_bus();
	endtask

	task automatic run_access(input int op);
		int          base;
		int          fetch_base;
		int          wb_base;
		logic [31:0] kind;
		logic        exp_stall;
		base = 2 + op * OP_WORDS;
		kind = stim[base];
		exp_stall = (stim[base + 4] != 32'd0) || (stim[base + 5] != 32'd0);
		@(posedge clk);
		proc_read  <= (kind == 32'd0);
		proc_write <= (kind == 32'd1);
		proc_addr  <= stim[base + 1][`PROC_ADDR_W-1:0];
		proc_wdata <= stim[base + 2];
		@(negedge clk);
		fetch_base = fetch_count;
		wb_base    = wb_count;
		// a hit completes in the cycle it appears, a miss stalls
		check_value("proc_stall", 32'(proc_stall), 32'(exp_stall));
		while (proc_stall) begin
			@(negedge clk);
		end
		if (kind == 32'd0) begin
			check_value("proc_rdata", proc_rdata, stim[base + 3]);
		end
		check_value("fetch count", 32'(fetch_count - fetch_base), stim[base + 4]);
		check_value("write-back count", 32'(wb_count - wb_base), stim[base + 5]);
		if (stim[base + 5] != 32'd0) begin
			check_value("mem_addr at write-back", 32'(last_wb_line), stim[base + 6]);
		end
		@(posedge clk);    // completing edge
		proc_read  <= 1'b0;
		proc_write <= 1'b0;
	endtask

	initial begin
		int          err_before;
		logic [31:0] kind;
		$readmemh("verification/cache_stimulus.txt", stim);
		mem_xor = stim[0];
		n_ops   = int'(stim[1]);
		if (n_ops < 1 || n_ops > MAX_OPS) begin
			errors++;
			$display("stimulus file does not hold a usable operation count");
			n_ops = 0;
		end
		watchdog_cycles = n_ops * 40;
		watch_reset_bus();
		for (int op = 0; op < n_ops; op++) begin
			err_before = errors;
			kind       = stim[2 + op * OP_WORDS];
			if (kind == 32'd2) begin
				pulse_reset();
			end else begin
				run_access(op);
			end
			$display("op %0d kind %0d addr %h: %s", op, kind, stim[3 + op * OP_WORDS],
				(errors == err_before) ? "ok" : "mismatch");
		end
		$display("%0d operations, %0d checks, %0d errors", n_ops, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// limit scales with the operation count
	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		$display("timeout, operations did not finish within %0d cycles", watchdog_cycles);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: verification/tb_clock.sv
// testbench clock and reset source, 10 ns clock and a 4-cycle proc_reset at start or on restart
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic proc_reset,
	input  logic restart    // runs the reset sequence again
);

	logic        reset_q = 1'b1;
	int unsigned reset_cycles = 0;

	assign proc_reset = reset_q;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (restart) begin
			reset_q      <= 1'b1;
			reset_cycles <= 0;
		end else if (reset_q) begin
			reset_cycles <= reset_cycles + 1;
			if (reset_cycles == 3) begin
				reset_q <= 1'b0;    // released after the 4th edge
			end
		end
	end

endmodule

// File: verilog/cache_ctrl.sv
// cache controller: tag compare, miss FSM and the memory request outputs
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_ctrl
	import cache_pkg::*;
(
	input  logic                    clk,
	input  logic                    proc_reset,

	// processor request
	input  logic                    proc_read,
	input  logic                    proc_write,
	input  logic [`PROC_ADDR_W-1:0] proc_addr,

	// entry at the request's index
	input  tag_entry_t              tag_entry,

	output logic                    proc_stall,

	// memory request
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [`MEM_ADDR_W-1:0]  mem_addr,
	input  logic                    mem_ready,

	// update strobes to line_update
	output logic                    fill_en,
	output logic                    wb_done,
	output logic                    hit_write
);

	cache_state_t state;
	cache_state_t state_next;

	logic req;
	logic hit;

	assign req = proc_read | proc_write;

	// valid line with a matching tag
	assign hit = tag_entry.valid && (tag_entry.tag == addr_tag(proc_addr));

	// ----------------------------------------
	// state register

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= reset_wait;
		end else begin
			state <= state_next;
		end
	end

	// ----------------------------------------
	// next state

	always_comb begin
		state_next = state;
		case (state)
			reset_wait: begin
				state_next = compare_tag;    // one stall cycle after reset
			end
			compare_tag: begin
				if (req && !hit) begin
					// dirty victim goes out before the new line comes in
					if (tag_entry.dirty) begin
						state_next = write_back;
					end else begin
						state_next = allocate;
					end
				end
			end
			write_back: begin
				if (mem_ready) begin
					state_next = allocate;
				end
			end
			allocate: begin
				if (mem_ready) begin
					state_next = compare_tag;    // access hits on return
				end
			end
		endcase
	end

	// ----------------------------------------
	// outputs

	always_comb begin
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = addr_line(proc_addr);
		fill_en    = 1'b0;
		wb_done    = 1'b0;
		hit_write  = 1'b0;
		case (state)
			reset_wait: begin
				proc_stall = 1'b1;
			end
			compare_tag: begin
				proc_stall = req && !hit;    // zero-cycle hit
				hit_write  = proc_write && hit;
			end
			write_back: begin
				mem_write = 1'b1;
				// old line lives at its stored tag and the same index
				mem_addr  = {tag_entry.tag, addr_index(proc_addr)};
				wb_done   = mem_ready;
			end
			allocate: begin
				mem_read = 1'b1;
				fill_en  = mem_ready;    // line written at the ready edge
			end
		endcase
	end

endmodule

// File: verilog/cache_defs.svh
// cache geometry macros, included by the package, the RTL modules and the testbench
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// direct-mapped, 8 lines of four words
`define CACHE_LINES 8
`define INDEX_W     3
`define OFFSET_W    2

// payload widths
`define WORD_W      32
`define LINE_W      128

// processor side is a word address, memory side a line address
`define TAG_W       25
`define PROC_ADDR_W 30
`define MEM_ADDR_W  28

`endif

// File: verilog/cache_pkg.sv
// shared cache types and address field helpers, imported by the RTL modules
`include "cache_defs.svh"

package cache_pkg;

	typedef logic [`WORD_W-1:0]   word_t;
	typedef logic [`LINE_W-1:0]   line_t;    // word 0 in the low bits
	typedef logic [`TAG_W-1:0]    tag_t;
	typedef logic [`INDEX_W-1:0]  index_t;
	typedef logic [`OFFSET_W-1:0] offset_t;

	typedef struct packed {
		logic valid;
		logic dirty;    // line differs from memory
		tag_t tag;
	} tag_entry_t;

	typedef enum logic [1:0] {
		reset_wait  = 2'd0,
		compare_tag = 2'd1,
		write_back  = 2'd2,
		allocate    = 2'd3
	} cache_state_t;

	// ----------------------------------------
	// word address fields: tag | index | offset

	function automatic tag_t addr_tag(input logic [`PROC_ADDR_W-1:0] addr);
		return addr[`PROC_ADDR_W-1 -: `TAG_W];
	endfunction

	function automatic index_t addr_index(input logic [`PROC_ADDR_W-1:0] addr);
		return addr[`OFFSET_W +: `INDEX_W];
	endfunction

	function automatic offset_t addr_offset(input logic [`PROC_ADDR_W-1:0] addr);
		return addr[`OFFSET_W-1:0];
	endfunction

	// line address as seen by memory
	function automatic logic [`MEM_ADDR_W-1:0] addr_line(input logic [`PROC_ADDR_W-1:0] addr);
		return addr[`PROC_ADDR_W-1:`OFFSET_W];
	endfunction

endpackage

// File: verilog/cache_top.sv
// direct-mapped write-back cache top level, connects controller, update logic and arrays
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top
	import cache_pkg::*;
(
	input  logic                    clk,
	input  logic                    proc_reset,

	// processor side, word addressed
	input  logic                    proc_read,
	input  logic                    proc_write,
	input  logic [`PROC_ADDR_W-1:0] proc_addr,
	input  word_t                   proc_wdata,
	output word_t                   proc_rdata,
	output logic                    proc_stall,

	// memory side, line addressed
	output logic                    mem_read,
	output logic                    mem_write,
	output logic [`MEM_ADDR_W-1:0]  mem_addr,
	output line_t                   mem_wdata,
	input  line_t                   mem_rdata,
	input  logic                    mem_ready
);

	index_t     line_index;
	tag_entry_t cur_tag;
	line_t      cur_line;

	logic       fill_en;
	logic       wb_done;
	logic       hit_write;

	logic       tag_wr_en;
	tag_entry_t tag_next;
	logic       data_wr_en;
	line_t      data_next;

	// both arrays read and write at the request's index
	assign line_index = addr_index(proc_addr);

	// ----------------------------------------
	// control

	cache_ctrl i_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.tag_entry  (cur_tag),
		.proc_stall (proc_stall),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_ready  (mem_ready),
		.fill_en    (fill_en),
		.wb_done    (wb_done),
		.hit_write  (hit_write)
	);

	line_update i_update (
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.fill_en    (fill_en),
		.wb_done    (wb_done),
		.hit_write  (hit_write),
		.mem_rdata  (mem_rdata),
		.cur_line   (cur_line),
		.cur_tag    (cur_tag),
		.tag_wr_en  (tag_wr_en),
		.tag_next   (tag_next),
		.data_wr_en (data_wr_en),
		.data_next  (data_next),
		.proc_rdata (proc_rdata),
		.mem_wdata  (mem_wdata)
	);

	// ----------------------------------------
	// storage

	line_array #(.entry_t(tag_entry_t)) i_tag_array (
		.clk        (clk),
		.proc_reset (proc_reset),
		.wr_en      (tag_wr_en),
		.wr_index   (line_index),
		.wr_entry   (tag_next),
		.rd_index   (line_index),
		.rd_entry   (cur_tag)
	);

	line_array #(.entry_t(line_t)) i_data_array (
		.clk        (clk),
		.proc_reset (proc_reset),
		.wr_en      (data_wr_en),
		.wr_index   (line_index),
		.wr_entry   (data_next),
		.rd_index   (line_index),
		.rd_entry   (cur_line)
	);

endmodule

// File: verilog/line_array.sv
// per-line register storage, one instance for the tag entries and one for the data lines
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_array
	import cache_pkg::*;
#(
	parameter type entry_t = line_t
) (
	input  logic   clk,
	input  logic   proc_reset,

	// write port, one entry per clock
	input  logic   wr_en,
	input  index_t wr_index,
	input  entry_t wr_entry,

	// combinational read
	input  index_t rd_index,
	output entry_t rd_entry
);

	entry_t entries [`CACHE_LINES];

	// ----------------------------------------
	// storage

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int i = 0; i < `CACHE_LINES; i++) begin
				entries[i] <= '0;    // invalid, clean
			end
		end else if (wr_en) begin
			entries[wr_index] <= wr_entry;
		end
	end

	// same-cycle lookup for hit detection and read data
	assign rd_entry = entries[rd_index];

endmodule

// File: verilog/line_update.sv
// builds next tag entry and data line from controller strobes, selects the read word
`timescale 1ns/1ps
`include "cache_defs.svh"

module line_update
	import cache_pkg::*;
(
	input  logic [`PROC_ADDR_W-1:0] proc_addr,
	input  word_t                   proc_wdata,

	// strobes from cache_ctrl
	input  logic                    fill_en,
	input  logic                    wb_done,
	input  logic                    hit_write,

	input  line_t                   mem_rdata,

	// current entries at the request's index
	input  line_t                   cur_line,
	input  tag_entry_t              cur_tag,

	// array write side
	output logic                    tag_wr_en,
	output tag_entry_t              tag_next,
	output logic                    data_wr_en,
	output line_t                   data_next,

	output word_t                   proc_rdata,
	output line_t                   mem_wdata
);

	offset_t offset;

	assign offset = addr_offset(proc_addr);

	assign tag_wr_en  = fill_en | wb_done | hit_write;
	assign data_wr_en = fill_en | hit_write;

	// ----------------------------------------
	// tag entry

	always_comb begin
		tag_next = cur_tag;
		if (fill_en) begin
			tag_next.valid = 1'b1;
			tag_next.dirty = 1'b0;    // fresh from memory
			tag_next.tag   = addr_tag(proc_addr);
		end else if (hit_write) begin
			tag_next.dirty = 1'b1;
		end else if (wb_done) begin
			tag_next.dirty = 1'b0;
		end
	end

	// ----------------------------------------
	// data line

	always_comb begin
		data_next = cur_line;
		if (fill_en) begin
			data_next = mem_rdata;
		end else begin
			data_next[int'(offset) * `WORD_W +: `WORD_W] = proc_wdata;    // merge one word
		end
	end

	assign proc_rdata = cur_line[int'(offset) * `WORD_W +: `WORD_W];

	// victim line for write-back
	assign mem_wdata = cur_line;

endmodule
